// File: tb.f
rtl/turfio_pkg.sv
rtl/turfio_cmd_decoder.sv
rtl/turfio_sync_timing.sv
rtl/turfio_trig_stamp.sv
rtl/turfio_cmd_path.sv
tb/tb_turfio_cmd_path.sv

// File: run.sh
#!/bin/sh
# Build the command path testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_turfio_cmd_path \
    -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "No errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: tb/tb_turfio_cmd_path.sv
module tb_turfio_cmd_path;

    // DUT ports
    logic                               sysclk_i;
    logic                               rst_n_i;
    logic [turfio_pkg::CMD_W-1:0]       command_i;
    logic                               command_valid_i;
    logic [turfio_pkg::PHASE_W-1:0]     sync_offset_i;
    logic                               en_ext_sync_i;
    logic                               sync_o;
    logic                               running_o;
    logic [turfio_pkg::COUNT_W-1:0]     sysclk_count_o;
    logic                               pps_o;
    logic                               trig_valid_o;
    logic [turfio_pkg::TRIG_TIME_W-1:0] trig_time_o;
    logic [turfio_pkg::COUNT_W-1:0]     trig_count_o;

    // Reference model state with one register per pipeline stage
    logic                               m_sync_p;
    logic                               m_reset_p;
    logic                               m_stop_p;
    logic                               m_pps_p;
    logic                               m_trig_p;
    logic [turfio_pkg::TRIG_TIME_W-1:0] m_dec_time;
    logic [turfio_pkg::PHASE_W-1:0]     m_phase;
    logic [turfio_pkg::COUNT_W-1:0]     m_count;
    logic                               m_running;
    logic                               m_tvalid;
    logic [turfio_pkg::TRIG_TIME_W-1:0] m_ttime;
    logic [turfio_pkg::COUNT_W-1:0]     m_tcount;

    // Config applied on the next falling edge
    logic [turfio_pkg::PHASE_W-1:0]     cfg_offset;
    logic                               cfg_en;
    // Outputs as seen on the last falling edge
    logic                               seen_sync;
    logic                               seen_pps;
    logic                               seen_tvalid;
    logic                               seen_running;

    logic [31:0] lfsr_state;
    int          err_count;
    int          check_count;
    int          test_num;
    int          test_err_start;
    string       test_name;

    turfio_cmd_path uut (
        .sysclk_i        (sysclk_i),
        .rst_n_i         (rst_n_i),
        .command_i       (command_i),
        .command_valid_i (command_valid_i),
        .sync_offset_i   (sync_offset_i),
        .en_ext_sync_i   (en_ext_sync_i),
        .sync_o          (sync_o),
        .running_o       (running_o),
        .sysclk_count_o  (sysclk_count_o),
        .pps_o           (pps_o),
        .trig_valid_o    (trig_valid_o),
        .trig_time_o     (trig_time_o),
        .trig_count_o    (trig_count_o)
    );

    // Period 40
    always #20 sysclk_i = ~sysclk_i;

    ////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////

    // Galois form shifting right with a feedback mask
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_cmd(input logic [1:0] code, input logic pps,
                                             input logic trig, input logic [14:0] ttime);
        logic [turfio_pkg::CMD_W-1:0] w;
        w = '0;
        w[turfio_pkg::RUNCMD_MSB:turfio_pkg::RUNCMD_LSB] = code;
        w[turfio_pkg::PPS_BIT] = pps;
        w[turfio_pkg::TRIG_BIT] = trig;
        w[turfio_pkg::TRIG_TIME_W-1:0] = ttime;
        return w;
    endfunction

    // All fields random including unused bits 27..15
    function automatic logic [31:0] random_cmd();
        logic [31:0] w;
        w = make_cmd(2'(rand_bits(2)), 1'(rand_bits(1)), 1'(rand_bits(1)),
                     15'(rand_bits(15)));
        w[turfio_pkg::TRIG_BIT-1:turfio_pkg::TRIG_TIME_W] = 13'(rand_bits(13));
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////

    task automatic model_reset();
        {m_sync_p, m_reset_p, m_stop_p, m_pps_p, m_trig_p} = '0;
        m_dec_time = '0;
        m_phase    = 4'(turfio_pkg::SYNC_PERIOD - 1);
        m_count    = '0;
        m_running  = 1'b0;
        m_tvalid   = 1'b0;
        m_ttime    = '0;
        m_tcount   = '0;
    endtask

    // One rising edge; later stages see the decoder pulses of the ending cycle
    task automatic model_step();
        logic [1:0] code;
        code = command_i[turfio_pkg::RUNCMD_MSB:turfio_pkg::RUNCMD_LSB];
        // Stamp takes the count before this edge
        m_tvalid = m_trig_p;
        if (m_trig_p) begin
            m_ttime  = m_dec_time;
            m_tcount = m_count;
        end
        if (m_sync_p && en_ext_sync_i) begin
            m_phase = sync_offset_i;
        end else begin
            m_phase = 4'((int'(m_phase) + 1) % turfio_pkg::SYNC_PERIOD);
        end
        if (m_reset_p) begin
            m_count = '0;
        end else begin
            m_count = m_count + 48'd1;
        end
        if (m_reset_p) begin
            m_running = 1'b1;
        end else if (m_stop_p) begin
            m_running = 1'b0;
        end
        // Decoder with one cycle of latency
        m_sync_p  = command_valid_i && (code == turfio_pkg::RUNCMD_SYNC);
        m_reset_p = command_valid_i && (code == turfio_pkg::RUNCMD_RESET);
        m_stop_p  = command_valid_i && (code == turfio_pkg::RUNCMD_STOP);
        m_pps_p   = command_valid_i && command_i[turfio_pkg::PPS_BIT];
        m_trig_p  = command_valid_i && command_i[turfio_pkg::TRIG_BIT];
        if (m_trig_p) begin
            m_dec_time = command_i[turfio_pkg::TRIG_TIME_W-1:0];
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Checking and cycle driver
    ////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("Error at time %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic compare_outputs();
        check_value("sync_o", 64'(m_phase == 4'd0), 64'(sync_o));
        check_value("running_o", 64'(m_running), 64'(running_o));
        check_value("sysclk_count_o", 64'(m_count), 64'(sysclk_count_o));
        check_value("pps_o", 64'(m_pps_p), 64'(pps_o));
        check_value("trig_valid_o", 64'(m_tvalid), 64'(trig_valid_o));
        check_value("trig_time_o", 64'(m_ttime), 64'(trig_time_o));
        check_value("trig_count_o", 64'(m_tcount), 64'(trig_count_o));
    endtask

    // Check and drive on the falling edge while the model follows the rising edge
    task automatic run_cycle(input logic valid, input logic [31:0] word);
        @(negedge sysclk_i);
        compare_outputs();
        seen_sync       = sync_o;
        seen_pps        = pps_o;
        seen_tvalid     = trig_valid_o;
        seen_running    = running_o;
        command_valid_i = valid;
        command_i       = word;
        sync_offset_i   = cfg_offset;
        en_ext_sync_i   = cfg_en;
        @(posedge sysclk_i);
        model_step();
    endtask

    // Idle cycles until an output reaches a level and count them as the latency
    task automatic wait_output(input string name, input logic level, input int limit,
                               output int cycles);
        logic hit;
        cycles = 0;
        hit = 1'b0;
        while (!hit && cycles < limit) begin
            run_cycle(1'b0, '0);
            cycles++;
            case (name)
                "sync_o":       hit = (seen_sync == level);
                "pps_o":        hit = (seen_pps == level);
                "trig_valid_o": hit = (seen_tvalid == level);
                "running_o":    hit = (seen_running == level);
                default:        hit = 1'b0;
            endcase
        end
        if (!hit) begin
            $display("Timeout: %s did not reach %0b within %0d cycles", name, level, limit);
            err_count++;
        end
    endtask

    task automatic test_begin(input string name);
        test_num++;
        test_name = name;
        test_err_start = err_count;
    endtask

    task automatic test_end();
        if (err_count == test_err_start) begin
            $display("test %0d %s: ok", test_num, test_name);
        end else begin
            $display("test %0d %s: %0d failures", test_num, test_name,
                     err_count - test_err_start);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        int cycles;
        sysclk_i        = 1'b0;
        rst_n_i         = 1'b0;
        command_i       = '0;
        command_valid_i = 1'b0;
        sync_offset_i   = '0;
        en_ext_sync_i   = 1'b0;
        cfg_offset      = '0;
        cfg_en          = 1'b0;
        lfsr_state      = 32'hf0fc;
        err_count       = 0;
        check_count     = 0;
        test_num        = 0;
        model_reset();

        // Reset values and then the first sync one edge out and every period after
        test_begin("reset and sync period");
        repeat (2) @(posedge sysclk_i);
        @(negedge sysclk_i);
        compare_outputs();
        rst_n_i = 1'b1;
        @(posedge sysclk_i);
        model_step();
        wait_output("sync_o", 1'b1, 4, cycles);
        check_value("first sync_o latency", 64'd1, 64'(cycles));
        wait_output("sync_o", 1'b1, 2 * turfio_pkg::SYNC_PERIOD, cycles);
        check_value("sync_o period", 64'(turfio_pkg::SYNC_PERIOD), 64'(cycles));
        test_end();

        // Run reset clears the count and starts the run before a stop ends it
        test_begin("run reset and stop");
        run_cycle(1'b1, make_cmd(turfio_pkg::RUNCMD_RESET, 1'b0, 1'b0, '0));
        wait_output("running_o", 1'b1, 8, cycles);
        check_value("running_o rise latency", 64'd2, 64'(cycles));
        repeat (5) run_cycle(1'b0, '0);
        run_cycle(1'b1, make_cmd(turfio_pkg::RUNCMD_STOP, 1'b0, 1'b0, '0));
        wait_output("running_o", 1'b0, 8, cycles);
        check_value("running_o fall latency", 64'd2, 64'(cycles));
        repeat (4) run_cycle(1'b0, '0);
        test_end();

        // Realign honoured only with the enable
        test_begin("external sync");
        cfg_offset = 4'(rand_bits(4));
        cfg_en = 1'b1;
        run_cycle(1'b1, make_cmd(turfio_pkg::RUNCMD_SYNC, 1'b0, 1'b0, '0));
        repeat (20) run_cycle(1'b0, '0);
        cfg_en = 1'b0;
        run_cycle(1'b1, make_cmd(turfio_pkg::RUNCMD_SYNC, 1'b0, 1'b0, '0));
        repeat (20) run_cycle(1'b0, '0);
        test_end();

        // Single and back-to-back PPS with a masked word in between
        test_begin("pps");
        run_cycle(1'b1, make_cmd(turfio_pkg::RUNCMD_NONE, 1'b1, 1'b0, '0));
        wait_output("pps_o", 1'b1, 4, cycles);
        check_value("pps_o latency", 64'd1, 64'(cycles));
        repeat (4) run_cycle(1'b1, make_cmd(turfio_pkg::RUNCMD_NONE, 1'b1, 1'b0, '0));
        run_cycle(1'b0, make_cmd(turfio_pkg::RUNCMD_NONE, 1'b1, 1'b0, '0));
        run_cycle(1'b1, make_cmd(turfio_pkg::RUNCMD_NONE, 1'b1, 1'b0, '0));
        repeat (3) run_cycle(1'b0, '0);
        test_end();

        // Stamped triggers with one sharing its word with a run reset
        test_begin("trigger stamps");
        run_cycle(1'b1, make_cmd(turfio_pkg::RUNCMD_NONE, 1'b0, 1'b1, 15'(rand_bits(15))));
        wait_output("trig_valid_o", 1'b1, 6, cycles);
        check_value("trig_valid_o latency", 64'd2, 64'(cycles));
        for (int i = 0; i < 8; i++) begin
            if (i == 3) begin
                run_cycle(1'b1, make_cmd(turfio_pkg::RUNCMD_RESET, 1'b0, 1'b1,
                                         15'(rand_bits(15))));
            end else begin
                run_cycle(1'b1, make_cmd(2'(rand_bits(2)), 1'b0, 1'b1, 15'(rand_bits(15))));
            end
        end
        repeat (4) run_cycle(1'b0, '0);
        test_end();

        // Long mixed stream with gaps in valid
        test_begin("random stream");
        cfg_offset = 4'(rand_bits(4));
        cfg_en = 1'(rand_bits(1));
        for (int i = 0; i < 500; i++) begin
            run_cycle(1'(rand_bits(1)), random_cmd());
        end
        repeat (4) run_cycle(1'b0, '0);
        test_end();

        $display("Summary: %0d tests, %0d checks, %0d failures",
                 test_num, check_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: rtl/turfio_cmd_path.sv
module turfio_cmd_path (
    input  logic                               sysclk_i,
    input  logic                               rst_n_i,
    // TURF command stream
    input  logic [turfio_pkg::CMD_W-1:0]       command_i,
    input  logic                               command_valid_i,
    // Sync configuration
    input  logic [turfio_pkg::PHASE_W-1:0]     sync_offset_i,
    input  logic                               en_ext_sync_i,
    // Timing outputs
    output logic                               sync_o,
    output logic                               running_o,
    output logic [turfio_pkg::COUNT_W-1:0]     sysclk_count_o,
    output logic                               pps_o,
    // Stamped triggers
    output logic                               trig_valid_o,
    output logic [turfio_pkg::TRIG_TIME_W-1:0] trig_time_o,
    output logic [turfio_pkg::COUNT_W-1:0]     trig_count_o
);

    //////////////////////////////////////////////////////////////////////
    // Internal links
    //////////////////////////////////////////////////////////////////////

    // Decoder run pulses
    logic                               run_sync;
    logic                               run_reset;
    logic                               run_stop;
    // Decoder trigger
    logic                               trig_pulse;
    logic [turfio_pkg::TRIG_TIME_W-1:0] trig_time;
    // Shared clock count
    logic [turfio_pkg::COUNT_W-1:0]     sysclk_count;

    assign sysclk_count_o = sysclk_count;

    //////////////////////////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////////////////////////

    // Command word to pulses, PPS goes straight out
    turfio_cmd_decoder u_decoder (
        .sysclk_i        (sysclk_i),
        .rst_n_i         (rst_n_i),
        .command_i       (command_i),
        .command_valid_i (command_valid_i),
        .run_sync_o      (run_sync),
        .run_reset_o     (run_reset),
        .run_stop_o      (run_stop),
        .pps_o           (pps_o),
        .trig_o          (trig_pulse),
        .trig_time_o     (trig_time)
    );

    // Sync phase, run state and clock count
    turfio_sync_timing u_timing (
        .sysclk_i       (sysclk_i),
        .rst_n_i        (rst_n_i),
        .run_sync_i     (run_sync),
        .run_reset_i    (run_reset),
        .run_stop_i     (run_stop),
        .sync_offset_i  (sync_offset_i),
        .en_ext_sync_i  (en_ext_sync_i),
        .sync_o         (sync_o),
        .running_o      (running_o),
        .sysclk_count_o (sysclk_count)
    );

    // Trigger timestamping
    turfio_trig_stamp u_stamp (
        .sysclk_i       (sysclk_i),
        .rst_n_i        (rst_n_i),
        .trig_i         (trig_pulse),
        .trig_time_i    (trig_time),
        .sysclk_count_i (sysclk_count),
        .trig_valid_o   (trig_valid_o),
        .trig_time_o    (trig_time_o),
        .trig_count_o   (trig_count_o)
    );

endmodule

// File: rtl/turfio_trig_stamp.sv
module turfio_trig_stamp (
    input  logic                               sysclk_i,
    input  logic                               rst_n_i,
    // Trigger pulse and time from the decoder
    input  logic                               trig_i,
    input  logic [turfio_pkg::TRIG_TIME_W-1:0] trig_time_i,
    // Running clock count
    input  logic [turfio_pkg::COUNT_W-1:0]     sysclk_count_i,
    // Stamped trigger event
    output logic                               trig_valid_o,
    output logic [turfio_pkg::TRIG_TIME_W-1:0] trig_time_o,
    output logic [turfio_pkg::COUNT_W-1:0]     trig_count_o
);

    //////////////////////////////////////////////////////////////////////
    // Event valid
    //////////////////////////////////////////////////////////////////////

    // One cycle behind the trigger pulse
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trig_valid_o <= 1'b0;
        end else begin
            trig_valid_o <= trig_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stamp capture
    //////////////////////////////////////////////////////////////////////

    // Time and count latched together on the trigger edge
    // Count is the value during the pulse cycle and not after
    // Outputs hold until the next trigger
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trig_time_o  <= '0;
            trig_count_o <= '0;
        end else if (trig_i) begin
            trig_time_o  <= trig_time_i;
            trig_count_o <= sysclk_count_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Valid can only stretch as far as the triggers behind it
    a_valid_width : assert property (
        @(posedge sysclk_i) disable iff (!rst_n_i)
        (trig_valid_o && $past(trig_valid_o)) |-> ($past(trig_i) && $past(trig_i, 2))
    );

endmodule

// File: rtl/turfio_sync_timing.sv
module turfio_sync_timing (
    input  logic                           sysclk_i,
    input  logic                           rst_n_i,
    // Run pulses from the decoder
    input  logic                           run_sync_i,
    input  logic                           run_reset_i,
    input  logic                           run_stop_i,
    // Static configuration
    input  logic [turfio_pkg::PHASE_W-1:0] sync_offset_i,
    input  logic                           en_ext_sync_i,
    // First cycle of each sync period
    output logic                           sync_o,
    // Run in progress
    output logic                           running_o,
    // System clock count
    output logic [turfio_pkg::COUNT_W-1:0] sysclk_count_o
);

    //////////////////////////////////////////////////////////////////////
    // Sync phase
    //////////////////////////////////////////////////////////////////////

    // Position inside the 16-cycle period
    logic [turfio_pkg::PHASE_W-1:0] phase_q;
    // Realign request that is actually honoured
    logic                           ext_load;

    // Run sync only counts when external sync is enabled
    assign ext_load = run_sync_i && en_ext_sync_i;

    // Out of reset at the last phase
    // so the first edge lands on phase 0
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q <= turfio_pkg::PHASE_RESET;
        end else if (ext_load) begin
            // Jump straight to the programmed offset
            phase_q <= sync_offset_i;
        end else begin
            // Wraps naturally since the period is a power of two
            phase_q <= phase_q + 1'b1;
        end
    end

    // Sync marks phase 0
    assign sync_o = (phase_q == '0);

    //////////////////////////////////////////////////////////////////////
    // Clock count
    //////////////////////////////////////////////////////////////////////

    // Free-running and cleared by a run reset
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sysclk_count_o <= '0;
        end else if (run_reset_i) begin
            sysclk_count_o <= '0;
        end else begin
            sysclk_count_o <= sysclk_count_o + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Run state
    //////////////////////////////////////////////////////////////////////

    // Reset starts a run and stop ends it
    // Decoder never raises both at once
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            running_o <= 1'b0;
        end else if (run_reset_i) begin
            running_o <= 1'b1;
        end else if (run_stop_i) begin
            running_o <= 1'b0;
        end
    end

    // Stop does not touch the count
    // the clock keeps running between runs

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Left alone, sync comes back one full period later
    // An honoured run sync anywhere in the window voids the attempt
    a_sync_period : assert property (
        @(posedge sysclk_i) disable iff (!rst_n_i || ext_load)
        sync_o |-> ##(turfio_pkg::SYNC_PERIOD) sync_o
    );

endmodule

// File: rtl/turfio_cmd_decoder.sv
module turfio_cmd_decoder (
    input  logic                               sysclk_i,
    input  logic                               rst_n_i,
    // Word from the TURF link, one per valid strobe
    input  logic [turfio_pkg::CMD_W-1:0]       command_i,
    input  logic                               command_valid_i,
    // Run control pulses
    output logic                               run_sync_o,
    output logic                               run_reset_o,
    output logic                               run_stop_o,
    // PPS via command
    output logic                               pps_o,
    // Trigger pulse and its time
    output logic                               trig_o,
    output logic [turfio_pkg::TRIG_TIME_W-1:0] trig_time_o
);

    //////////////////////////////////////////////////////////////////////
    // Field extraction
    //////////////////////////////////////////////////////////////////////

    // Run command code
    logic [turfio_pkg::RUNCMD_MSB-turfio_pkg::RUNCMD_LSB:0] run_cmd;
    // Trigger flag and PPS flag
    logic                                                    trig_flag;
    logic                                                    pps_flag;

    assign run_cmd   = command_i[turfio_pkg::RUNCMD_MSB:turfio_pkg::RUNCMD_LSB];
    assign trig_flag = command_i[turfio_pkg::TRIG_BIT];
    assign pps_flag  = command_i[turfio_pkg::PPS_BIT];

    //////////////////////////////////////////////////////////////////////
    // Pulse registers
    //////////////////////////////////////////////////////////////////////

    // Every pulse is rebuilt each cycle, so no valid means all low
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_sync_o  <= 1'b0;
            run_reset_o <= 1'b0;
            run_stop_o  <= 1'b0;
            pps_o       <= 1'b0;
            trig_o      <= 1'b0;
        end else begin
            // Code NONE decodes to nothing
            run_sync_o  <= command_valid_i && (run_cmd == turfio_pkg::RUNCMD_SYNC);
            run_reset_o <= command_valid_i && (run_cmd == turfio_pkg::RUNCMD_RESET);
            run_stop_o  <= command_valid_i && (run_cmd == turfio_pkg::RUNCMD_STOP);
            // Flags are independent of the run code
            pps_o       <= command_valid_i && pps_flag;
            trig_o      <= command_valid_i && trig_flag;
        end
    end

    // Trigger time rides with trig_o
    // Only loaded by an actual trigger word
    always_ff @(posedge sysclk_i) begin
        if (command_valid_i && trig_flag) begin
            trig_time_o <= command_i[turfio_pkg::TRIG_TIME_W-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Any pulse output at all
    logic any_pulse;
    assign any_pulse = run_sync_o | run_reset_o | run_stop_o | pps_o | trig_o;

    // One 2-bit code, so the run pulses never overlap
    a_run_onehot : assert property (
        @(posedge sysclk_i) disable iff (!rst_n_i)
        $onehot0({run_sync_o, run_reset_o, run_stop_o})
    );

    // A pulse two cycles wide needs two valid words back to back
    a_pulse_width : assert property (
        @(posedge sysclk_i) disable iff (!rst_n_i)
        (any_pulse && $past(any_pulse)) |->
            ($past(command_valid_i) && $past(command_valid_i, 2))
    );

endmodule

// File: rtl/turfio_pkg.sv
package turfio_pkg;

    //////////////////////////////////////////////////////////////////////
    // Command word format
    //////////////////////////////////////////////////////////////////////

    // Full width of a word from the TURF link
    localparam int CMD_W = 32;

    // Run command field in the top two bits
    localparam int RUNCMD_MSB = 31;
    localparam int RUNCMD_LSB = 30;

    // Run command codes
    localparam logic [1:0] RUNCMD_NONE  = 2'd0;
    localparam logic [1:0] RUNCMD_SYNC  = 2'd1;
    localparam logic [1:0] RUNCMD_RESET = 2'd2;
    localparam logic [1:0] RUNCMD_STOP  = 2'd3;

    // Single-bit flags
    localparam int PPS_BIT  = 29;
    localparam int TRIG_BIT = 28;

    // Trigger time sits at the bottom of the word
    localparam int TRIG_TIME_W = 15;

    //////////////////////////////////////////////////////////////////////
    // System clock timing
    //////////////////////////////////////////////////////////////////////

    // Free-running clock count
    localparam int COUNT_W = 48;

    // Sync period in sysclk cycles, phase and offset width to match
    localparam int SYNC_PERIOD = 16;
    localparam int PHASE_W     = 4;

    // Last phase of a period, which is where the counter sits out of reset
    localparam logic [PHASE_W-1:0] PHASE_RESET = PHASE_W'(SYNC_PERIOD - 1);

endpackage
